// File: exe_pkg.sv
package exe_pkg;

  // **************************************************
  // widths
  // **************************************************
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  // operation codes, values fixed for the stimulus file
  typedef enum logic [4:0] {
    OP_OR    = 5'd0,
    OP_AND   = 5'd1,
    OP_XOR   = 5'd2,
    OP_NOR   = 5'd3,
    OP_SLL   = 5'd4,
    OP_SRL   = 5'd5,
    OP_SRA   = 5'd6,
    OP_ADD   = 5'd7,
    OP_ADDU  = 5'd8,
    OP_SUB   = 5'd9,
    OP_SUBU  = 5'd10,
    OP_SLT   = 5'd11,
    OP_SLTU  = 5'd12,
    OP_CLZ   = 5'd13,
    OP_CLO   = 5'd14,
    OP_MUL   = 5'd15,
    OP_MULT  = 5'd16,
    OP_MULTU = 5'd17,
    OP_MFHI  = 5'd18,
    OP_MFLO  = 5'd19,
    OP_MTHI  = 5'd20,
    OP_MTLO  = 5'd21
  } exe_op_e;

  // **************************************************
  // command, result and hi/lo pair
  // **************************************************
  typedef struct packed {
    exe_op_e               op;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic [REG_ADDR_W-1:0] dest;
    logic                  wen;
  } exe_cmd_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       data;
    logic                  wen;
  } exe_res_t;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } hilo_t;

  // op classes
  function automatic logic is_hilo_write(input exe_op_e op);
    return op inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO};
  endfunction

  function automatic logic is_hilo_read(input exe_op_e op);
    return op inside {OP_MFHI, OP_MFLO};
  endfunction

  function automatic logic is_ov_checked(input exe_op_e op);
    return op inside {OP_ADD, OP_SUB};
  endfunction

endpackage

// File: exe_fifo.sv
`timescale 1ns/1ns

module exe_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0],
  localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CNT_W     = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  payload_t         push_data_i,
  input  logic             pop_i,
  output payload_t         pop_data_o,
  output logic             empty_o,
  output logic [CNT_W-1:0] free_o
);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop_i)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem[wr_ptr] <= push_data_i;
  end

  // show-ahead read
  assign pop_data_o = mem[rd_ptr];
  assign empty_o    = (count == '0);
  assign free_o     = CNT_W'(DEPTH) - count;

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count != CNT_W'(DEPTH)));
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// File: exe_logic_shift.sv
`timescale 1ns/1ns

module exe_logic_shift
  import exe_pkg::*;
(
  input  exe_op_e         op_i,
  input  logic [XLEN-1:0] rs_i,
  input  logic [XLEN-1:0] rt_i,
  output logic [XLEN-1:0] res_o
);

  logic [SHAMT_W-1:0] shamt;

  // shift amount from rs, value from rt
  assign shamt = rs_i[SHAMT_W-1:0];

  always_comb
  begin
    case (op_i)
      OP_OR:
        res_o = rs_i | rt_i;
      OP_AND:
        res_o = rs_i & rt_i;
      OP_XOR:
        res_o = rs_i ^ rt_i;
      OP_NOR:
        res_o = ~(rs_i | rt_i);
      OP_SLL:
        res_o = rt_i << shamt;
      OP_SRL:
        res_o = rt_i >> shamt;
      // sign bit copied in from the left
      OP_SRA:
        res_o = $signed(rt_i) >>> shamt;
      default:
        res_o = '0;
    endcase
  end

endmodule

// File: exe_arith.sv
`timescale 1ns/1ns

module exe_arith
  import exe_pkg::*;
(
  input  exe_op_e         op_i,
  input  logic [XLEN-1:0] rs_i,
  input  logic [XLEN-1:0] rt_i,
  output logic [XLEN-1:0] res_o,
  output logic            ov_o
);

  localparam int CNT_W = $clog2(XLEN + 1);

  logic            sub_op;
  logic [XLEN-1:0] rt_mux;
  logic [XLEN-1:0] sum;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [XLEN-1:0] lead_src;
  logic [CNT_W-1:0] lead_cnt;

  // counts leading zero bits, all zero gives XLEN
  function automatic logic [CNT_W-1:0] lead_zeros(input logic [XLEN-1:0] v);
    logic [CNT_W-1:0] n;
    logic             found;
    n     = '0;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--)
    begin
      if (!found)
      begin
        if (v[i])
          found = 1'b1;
        else
          n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // two's complement of rt for subtract and compare
  assign sub_op = op_i inside {OP_SUB, OP_SUBU, OP_SLT};
  assign rt_mux = sub_op ? (~rt_i + 1'b1) : rt_i;
  assign sum    = rs_i + rt_mux;

  // operands of equal effective sign, result sign flipped
  assign ov_o = is_ov_checked(op_i) &&
                (rs_i[XLEN-1] == (rt_i[XLEN-1] ^ sub_op)) &&
                (sum[XLEN-1] != rs_i[XLEN-1]);

  assign lt_signed   = (rs_i[XLEN-1] && !rt_i[XLEN-1]) ||
                       ((rs_i[XLEN-1] == rt_i[XLEN-1]) && sum[XLEN-1]);
  assign lt_unsigned = (rs_i < rt_i);

  // clo is clz of the inverted word
  assign lead_src = (op_i == OP_CLO) ? ~rs_i : rs_i;
  assign lead_cnt = lead_zeros(lead_src);

  always_comb
  begin
    case (op_i)
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
        res_o = sum;
      OP_SLT:
        res_o = XLEN'(lt_signed);
      OP_SLTU:
        res_o = XLEN'(lt_unsigned);
      OP_CLZ, OP_CLO:
        res_o = XLEN'(lead_cnt);
      default:
        res_o = '0;
    endcase
  end

endmodule

// File: exe_mult.sv
`timescale 1ns/1ns

module exe_mult
  import exe_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  exe_op_e         op_i,
  input  logic [XLEN-1:0] rs_i,
  input  logic [XLEN-1:0] rt_i,
  output hilo_t           prod_o
);

  logic              sgn;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic              s1_vld;
  logic              neg_q;
  logic [XLEN-1:0]   a_q;
  logic [XLEN-1:0]   b_q;
  logic [2*XLEN-1:0] full_prod;
  hilo_t             prod_q;

  // **************************************************
  // stage 1: magnitudes and sign
  // **************************************************
  assign sgn   = op_i inside {OP_MUL, OP_MULT};
  assign mag_a = (sgn && rs_i[XLEN-1]) ? (~rs_i + 1'b1) : rs_i;
  assign mag_b = (sgn && rt_i[XLEN-1]) ? (~rt_i + 1'b1) : rt_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      s1_vld <= 1'b0;
    else
      s1_vld <= start_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      a_q   <= mag_a;
      b_q   <= mag_b;
      neg_q <= sgn && (rs_i[XLEN-1] ^ rt_i[XLEN-1]);
    end
  end

  // stage 2: product, sign restored
  assign full_prod = a_q * b_q;

  always_ff @(posedge clk_i)
  begin
    if (s1_vld)
      prod_q <= hilo_t'(neg_q ? (~full_prod + 1'b1) : full_prod);
  end

  assign prod_o = prod_q;

endmodule

// File: exe_hilo.sv
`timescale 1ns/1ns

module exe_hilo
  import exe_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  we_i,
  input  hilo_t wdata_i,
  output hilo_t hilo_o
);

  hilo_t hilo_q;

  // architectural pair, both halves loaded together
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      hilo_q <= '0;
    else if (we_i)
      hilo_q <= wdata_i;
  end

  assign hilo_o = hilo_q;

  // the kept half comes back from this register through the control
  a_wdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> !$isunknown(wdata_i));

endmodule

// File: exe_ctrl.sv
`timescale 1ns/1ns

module exe_ctrl
  import exe_pkg::*;
#(
  parameter int  RES_DEPTH   = 4,
  parameter int  RES_CREDITS = 2,
  localparam int FREE_W      = $clog2(RES_DEPTH + 1),
  localparam int CRED_W      = $clog2(RES_CREDITS + 1)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cmd_empty_i,
  input  exe_cmd_t          cmd_head_i,
  output logic              cmd_pop_o,
  input  logic [XLEN-1:0]   ls_res_i,
  input  logic [XLEN-1:0]   ar_res_i,
  input  logic              ar_ov_i,
  output logic              issue_o,
  input  hilo_t             mult_prod_i,
  input  hilo_t             hilo_i,
  output logic              hilo_we_o,
  output hilo_t             hilo_wdata_o,
  input  logic [FREE_W-1:0] res_free_i,
  output logic              res_push_o,
  output exe_res_t          res_data_o,
  input  logic              res_empty_i,
  output logic              res_pop_o,
  input  logic              res_credit_i
);

  logic              s1_vld;
  logic              s2_vld;
  exe_cmd_t          s1_cmd;
  exe_cmd_t          s2_cmd;
  exe_res_t          s1_res;
  exe_res_t          s2_res;
  exe_res_t          s1_next;
  logic [1:0]        n_inflight;
  logic              hilo_busy;
  logic [CRED_W-1:0] credit_cnt;

  // **************************************************
  // issue
  // **************************************************
  assign n_inflight = {1'b0, s1_vld} + {1'b0, s2_vld};

  // hi/lo readers wait until every older writer has retired
  assign hilo_busy = (s1_vld && is_hilo_write(s1_cmd.op)) ||
                     (s2_vld && is_hilo_write(s2_cmd.op));

  assign issue_o = !cmd_empty_i &&
                   (res_free_i > FREE_W'(n_inflight)) &&
                   !(is_hilo_read(cmd_head_i.op) && hilo_busy);
  assign cmd_pop_o = issue_o;

  // stage 1 value, mul is patched at stage 2
  always_comb
  begin
    s1_next.dest = cmd_head_i.dest;
    s1_next.wen  = cmd_head_i.wen && !ar_ov_i && !is_hilo_write(cmd_head_i.op);
    case (cmd_head_i.op)
      OP_OR, OP_AND, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA:
        s1_next.data = ls_res_i;
      OP_MFHI:
        s1_next.data = hilo_i.hi;
      OP_MFLO:
        s1_next.data = hilo_i.lo;
      default:
        s1_next.data = ar_res_i;
    endcase
  end

  // **************************************************
  // pipeline
  // **************************************************
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end
    else
    begin
      s1_vld <= issue_o;
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_o)
    begin
      s1_cmd <= cmd_head_i;
      s1_res <= s1_next;
    end
    s2_cmd <= s1_cmd;
    s2_res <= s1_res;
  end

  assign res_push_o = s2_vld;

  always_comb
  begin
    res_data_o = s2_res;
    if (s2_cmd.op == OP_MUL)
      res_data_o.data = mult_prod_i.lo;
  end

  // hi/lo write at stage 2, the untouched half comes from the current pair
  assign hilo_we_o = s2_vld && is_hilo_write(s2_cmd.op);

  always_comb
  begin
    hilo_wdata_o = hilo_i;
    case (s2_cmd.op)
      OP_MULT, OP_MULTU:
        hilo_wdata_o = mult_prod_i;
      OP_MTHI:
        hilo_wdata_o.hi = s2_cmd.rs_val;
      OP_MTLO:
        hilo_wdata_o.lo = s2_cmd.rs_val;
      default:
        hilo_wdata_o = hilo_i;
    endcase
  end

  // **************************************************
  // output credits
  // **************************************************
  assign res_pop_o = (credit_cnt != '0) && !res_empty_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      credit_cnt <= CRED_W'(RES_CREDITS);
    else if (res_pop_o && !res_credit_i)
      credit_cnt <= credit_cnt - 1'b1;
    else if (!res_pop_o && res_credit_i)
      credit_cnt <= credit_cnt + 1'b1;
  end

  // last credit spent with none coming back, no send in the next cycle
  a_send_with_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_pop_o && !res_credit_i && (credit_cnt == CRED_W'(1))) |=> !res_pop_o);
  // receiver returns no more than it was given
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_credit_i && !res_pop_o) |-> (credit_cnt < CRED_W'(RES_CREDITS)));

endmodule

// File: exe_unit.sv
`timescale 1ns/1ns

module exe_unit
  import exe_pkg::*;
#(
  parameter int CMD_DEPTH   = 4,
  parameter int RES_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     cmd_valid_i,
  input  exe_cmd_t cmd_i,
  output logic     cmd_credit_o,
  output logic     res_valid_o,
  output exe_res_t res_o,
  input  logic     res_credit_i
);

  exe_cmd_t                         cmd_head;
  logic                             cmd_empty;
  logic                             cmd_pop;
  logic [XLEN-1:0]                  ls_res;
  logic [XLEN-1:0]                  ar_res;
  logic                             ar_ov;
  logic                             issue;
  hilo_t                            mult_prod;
  hilo_t                            hilo;
  logic                             hilo_we;
  hilo_t                            hilo_wdata;
  logic [$clog2(RES_DEPTH + 1)-1:0] res_free;
  logic                             res_push;
  exe_res_t                         res_data;
  logic                             res_empty;
  logic                             res_pop;

  assign cmd_credit_o = cmd_pop;
  assign res_valid_o  = res_pop;

  // **************************************************
  // queues
  // **************************************************
  exe_fifo #(.DEPTH(CMD_DEPTH), .payload_t(exe_cmd_t)) cmd_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (cmd_valid_i),
    .push_data_i (cmd_i),
    .pop_i       (cmd_pop),
    .pop_data_o  (cmd_head),
    .empty_o     (cmd_empty),
    .free_o      ()
  );

  exe_fifo #(.DEPTH(RES_DEPTH), .payload_t(exe_res_t)) res_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (res_push),
    .push_data_i (res_data),
    .pop_i       (res_pop),
    .pop_data_o  (res_o),
    .empty_o     (res_empty),
    .free_o      (res_free)
  );

  exe_ctrl #(.RES_DEPTH(RES_DEPTH), .RES_CREDITS(RES_CREDITS)) ctrl0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_empty_i  (cmd_empty),
    .cmd_head_i   (cmd_head),
    .cmd_pop_o    (cmd_pop),
    .ls_res_i     (ls_res),
    .ar_res_i     (ar_res),
    .ar_ov_i      (ar_ov),
    .issue_o      (issue),
    .mult_prod_i  (mult_prod),
    .hilo_i       (hilo),
    .hilo_we_o    (hilo_we),
    .hilo_wdata_o (hilo_wdata),
    .res_free_i   (res_free),
    .res_push_o   (res_push),
    .res_data_o   (res_data),
    .res_empty_i  (res_empty),
    .res_pop_o    (res_pop),
    .res_credit_i (res_credit_i)
  );

  // datapath on the head command
  exe_logic_shift ls0 (
    .op_i  (cmd_head.op),
    .rs_i  (cmd_head.rs_val),
    .rt_i  (cmd_head.rt_val),
    .res_o (ls_res)
  );

  exe_arith ar0 (
    .op_i  (cmd_head.op),
    .rs_i  (cmd_head.rs_val),
    .rt_i  (cmd_head.rt_val),
    .res_o (ar_res),
    .ov_o  (ar_ov)
  );

  exe_mult mult0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (issue),
    .op_i    (cmd_head.op),
    .rs_i    (cmd_head.rs_val),
    .rt_i    (cmd_head.rt_val),
    .prod_o  (mult_prod)
  );

  exe_hilo hilo0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .we_i    (hilo_we),
    .wdata_i (hilo_wdata),
    .hilo_o  (hilo)
  );

endmodule

// File: tb_exe_unit.sv
`timescale 1ns/1ns

module tb_exe_unit
  import exe_pkg::*;
();

  localparam int          CLK_HALF     = 2;
  localparam int          RST_CYCLES   = 4;
  // matches the default CMD_DEPTH of the DUT
  localparam int          CMD_CREDITS  = 4;
  // matches the default RES_CREDITS of the DUT
  localparam int          RES_SLOTS    = 2;
  localparam int          MAX_LINES    = 64;
  localparam int          COLS         = 7;
  localparam int          DRAIN_CYCLES = 12;
  localparam logic [31:0] SEED         = 32'hdc87;
  localparam              DATA_FILE    = "exe_testdata.hex";

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  exe_cmd_t    cmd;
  logic        cmd_credit;
  logic        res_valid;
  exe_res_t    res;
  logic        res_credit;

  logic [31:0] tdata [MAX_LINES*COLS];
  int          n_lines;
  logic        loaded;
  int          send_ptr;
  int          exp_ptr;
  int          snd_credits;
  int          rcv_slots;
  int          ret_delay [$];
  logic [31:0] rng;

  exe_unit dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_credit_o (cmd_credit),
    .res_valid_o  (res_valid),
    .res_o        (res),
    .res_credit_i (res_credit)
  );

  always #CLK_HALF clk = ~clk;

  // **************************************************
  // helpers
  // **************************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] file_word(input int idx, input int col);
    return tdata[idx*COLS + col];
  endfunction

  function automatic exe_cmd_t cmd_from_line(input int idx);
    exe_cmd_t    c;
    logic [31:0] op_w;
    op_w     = file_word(idx, 0);
    c.op     = exe_op_e'(op_w[4:0]);
    c.rs_val = file_word(idx, 1);
    c.rt_val = file_word(idx, 2);
    c.dest   = REG_ADDR_W'(file_word(idx, 3));
    c.wen    = (file_word(idx, 4) != 32'd0);
    return c;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  // hi/lo writers carry no register value, only dest and wen count
  task automatic check_result(input exe_res_t got, input int idx);
    logic [31:0] op_w;
    exe_op_e     op;
    op_w = file_word(idx, 0);
    op   = exe_op_e'(op_w[4:0]);
    check_val($sformatf("res_o.dest, line %0d", idx), 64'(got.dest),
              64'(file_word(idx, 3)));
    if (!(op inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO}))
      check_val($sformatf("res_o.data, line %0d", idx), 64'(got.data),
                64'(file_word(idx, 5)));
    check_val($sformatf("res_o.wen, line %0d", idx), 64'(got.wen),
              64'(file_word(idx, 6)));
  endtask

  // **************************************************
  // one falling edge: sample outputs, then drive inputs
  // **************************************************
  task automatic run_cycle();
    logic     credit_back;
    logic     got_valid;
    exe_res_t got_res;
    credit_back = cmd_credit;
    got_valid   = res_valid;
    got_res     = res;

    // a result needs a free receiver slot
    if (got_valid && rcv_slots == 0)
      fail_run("a result arrived while the receiver had no free slot");
    else if (got_valid)
      rcv_slots--;

    // a returned credit is usable from the next cycle on
    if (send_ptr < n_lines && snd_credits > 0)
    begin
      cmd_valid = 1'b1;
      cmd       = cmd_from_line(send_ptr);
      send_ptr++;
      snd_credits--;
    end
    else
    begin
      cmd_valid = 1'b0;
    end
    if (credit_back)
      snd_credits++;
    if (snd_credits > CMD_CREDITS)
      fail_run("the DUT returned a command credit that was never spent");

    // receiver frees its slots one at a time
    res_credit = 1'b0;
    if (ret_delay.size() > 0)
    begin
      if (ret_delay[0] == 0)
      begin
        res_credit = 1'b1;
        rcv_slots++;
        void'(ret_delay.pop_front());
      end
      else
        ret_delay[0] = ret_delay[0] - 1;
    end

    if (got_valid && exp_ptr >= n_lines)
      fail_run("a result arrived with no command left to match it");
    else if (got_valid)
    begin
      check_result(got_res, exp_ptr);
      exp_ptr++;
      rng = xorshift32(rng);
      ret_delay.push_back(int'(rng[1:0]));
    end
  endtask

  // **************************************************
  // main sequence
  // **************************************************
  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    res_credit  = 1'b0;
    loaded      = 1'b0;
    n_lines     = 0;
    send_ptr    = 0;
    exp_ptr     = 0;
    snd_credits = CMD_CREDITS;
    rcv_slots   = RES_SLOTS;
    rng         = SEED;

    // unused entries hold no valid op code
    for (int i = 0; i < MAX_LINES*COLS; i++)
      tdata[i] = {16'hdead, 16'(i)};
    $readmemh(DATA_FILE, tdata);
    while (n_lines < MAX_LINES && file_word(n_lines, 0) <= 32'(OP_MTLO))
      n_lines++;

    if (n_lines == 0)
      fail_run("no commands were read from the test data file");
    else
    begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      while (exp_ptr < n_lines)
      begin
        @(negedge clk);
        run_cycle();
      end
      // nothing more may come out, every command credit must be back
      repeat (DRAIN_CYCLES)
      begin
        @(negedge clk);
        run_cycle();
      end
      check_val("command credits after drain", 64'(snd_credits), 64'(CMD_CREDITS));
      $display("Simulation passed");
      $finish;
    end
  end

  // watchdog, sized from the number of commands
  initial
  begin
    wait (loaded);
    repeat (40 * n_lines + 100) @(posedge clk);
    $display("results stopped arriving before the end of the test data");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: exe_testdata.hex
// columns: op rs rt dest wen expected_data expected_wen
// expected_data is not compared for mult, multu, mthi and mtlo
00 f0f0f0f0 0ff00ff0 01 1 fff0fff0 1
01 f0f0f0f0 0ff00ff0 02 1 00f000f0 1
02 f0f0f0f0 0ff00ff0 03 0 ff00ff00 0
03 12345678 0000ffff 04 1 edcb0000 1
04 00000024 000000ff 05 1 00000ff0 1
05 00000008 80000000 06 1 00800000 1
06 00000008 80000000 07 1 ff800000 1
07 7fffffff 00000001 08 1 80000000 0
08 7fffffff 00000001 09 1 80000000 1
09 80000000 00000001 0a 1 7fffffff 0
0a 80000000 00000001 0b 1 7fffffff 1
07 00000005 fffffffd 0c 1 00000002 1
0b ffffffff 00000001 0d 1 00000001 1
0c ffffffff 00000001 0e 1 00000000 1
0d 00000000 00000000 0f 1 00000020 1
0e ffffffff 00000000 10 1 00000020 1
0d 00010000 00000000 11 1 0000000f 1
0e fff00000 00000000 12 1 0000000c 1
0f fffffffe 00000003 13 1 fffffffa 1
10 fffffffe 00000003 14 1 00000000 0
12 00000000 00000000 15 1 ffffffff 1
13 00000000 00000000 16 1 fffffffa 1
11 fffffffe 00000003 17 1 00000000 0
12 00000000 00000000 18 1 00000002 1
13 00000000 00000000 19 1 fffffffa 1
14 aaaa5555 00000000 1a 1 00000000 0
13 00000000 00000000 1b 1 fffffffa 1
12 00000000 00000000 1c 1 aaaa5555 1
15 11112222 00000000 1d 1 00000000 0
13 00000000 00000000 1e 1 11112222 1
12 00000000 00000000 1f 1 aaaa5555 1
0f 00012345 00000100 01 1 01234500 1

// File: sim.f
exe_pkg.sv
exe_fifo.sv
exe_logic_shift.sv
exe_arith.sv
exe_mult.sv
exe_hilo.sv
exe_ctrl.sv
exe_unit.sv
tb_exe_unit.sv
